// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu (
	input  logic [cpu_pkg::WORD_W-1:0]   a,
	input  logic [cpu_pkg::WORD_W-1:0]   b,
	input  logic [cpu_pkg::OP_W-1:0]     alu_op,
	input  logic                         pc_increment,
	output logic [2*cpu_pkg::WORD_W-1:0] result
);

	logic [4:0]                          amt;         // Shift and rotate count
	logic signed [2*cpu_pkg::WORD_W-1:0] product;
	logic                                div_by_zero;
	logic                                div_by_neg1;
	logic [cpu_pkg::WORD_W-1:0]          quotient;
	logic [cpu_pkg::WORD_W-1:0]          remainder;
	logic [2*cpu_pkg::WORD_W-1:0]        ror_pair;
	logic [2*cpu_pkg::WORD_W-1:0]        rol_pair;
	logic [cpu_pkg::WORD_W-1:0]          word;        // Result of the 32-bit operations

	assign amt = b[4:0];

	// Both operands signed and extended to 64 bits
	assign product = $signed(a) * $signed(b);

	// Divide by zero and by -1 bypass the divider
	assign div_by_zero = (b == '0);
	assign div_by_neg1 = (b == '1);

	always_comb begin
		if (div_by_zero) begin
			quotient  = '1;
			remainder = a;         // Dividend passes through
		end else if (div_by_neg1) begin
			quotient  = -a;        // Wraps for the most negative dividend
			remainder = '0;
		end else begin
			quotient  = $signed(a) / $signed(b);
			remainder = $signed(a) % $signed(b); // Takes the sign of a
		end
	end

	// Rotates through a doubled word
	assign ror_pair = {a, a} >> amt;
	assign rol_pair = {a, a} << amt;

	always_comb begin
		case (alu_op)
			cpu_pkg::OP_AND:  word = a & b;
			cpu_pkg::OP_OR:   word = a | b;
			cpu_pkg::OP_ADD:  word = a + b;
			cpu_pkg::OP_SUB:  word = a - b;
			cpu_pkg::OP_SHR:  word = a >> amt;
			cpu_pkg::OP_SHRA: word = $signed(a) >>> amt;
			cpu_pkg::OP_SHL:  word = a << amt;
			cpu_pkg::OP_ROR:  word = ror_pair[cpu_pkg::WORD_W-1:0];
			cpu_pkg::OP_ROL:  word = rol_pair[2*cpu_pkg::WORD_W-1:cpu_pkg::WORD_W];
			cpu_pkg::OP_NEG:  word = -b;
			cpu_pkg::OP_NOT:  word = ~b;
			default:          word = '0;
		endcase
	end

	// Increment wins over any opcode
	always_comb begin
		if (pc_increment) begin
			result = {{cpu_pkg::WORD_W{1'b0}}, b + 32'd1};
		end else if (alu_op == cpu_pkg::OP_MUL) begin
			result = product;
		end else if (alu_op == cpu_pkg::OP_DIV) begin
			result = {remainder, quotient};
		end else begin
			result = {{cpu_pkg::WORD_W{1'b0}}, word}; // Unknown op gives all zeros
		end
	end

endmodule

// ==== rtl/bus_encoder.sv ====
`timescale 1ns/10ps

module bus_encoder (
	input  logic [cpu_pkg::WORD_W-1:0]  gpr_q [cpu_pkg::NUM_GPR],
	input  logic [cpu_pkg::NUM_GPR-1:0] gpr_select,
	input  logic                        pc_select,
	input  logic                        z_hi_select,
	input  logic                        z_lo_select,
	input  logic                        mdr_select,
	input  logic [cpu_pkg::WORD_W-1:0]  pc_data,
	input  logic [cpu_pkg::WORD_W-1:0]  z_hi_data,
	input  logic [cpu_pkg::WORD_W-1:0]  z_lo_data,
	input  logic [cpu_pkg::WORD_W-1:0]  mdr_data,
	output logic [cpu_pkg::WORD_W-1:0]  bus_data,
	output logic [cpu_pkg::SRC_W-1:0]   encode_sel
);

	// Priority encode of the select lines
	// Assignments run from lowest to highest priority, so the last hit wins:
	// MDR, PC, Z lo, Z hi, then R15 down to R0
	always_comb begin
		encode_sel = cpu_pkg::SRC_NONE;
		if (mdr_select) begin
			encode_sel = cpu_pkg::SRC_MDR;
		end
		if (pc_select) begin
			encode_sel = cpu_pkg::SRC_PC;
		end
		if (z_lo_select) begin
			encode_sel = cpu_pkg::SRC_Z_LO;
		end
		if (z_hi_select) begin
			encode_sel = cpu_pkg::SRC_Z_HI;
		end
		for (int i = cpu_pkg::NUM_GPR - 1; i >= 0; i--) begin
			if (gpr_select[i]) begin
				encode_sel = i[cpu_pkg::SRC_W-1:0]; // GPR code is its index
			end
		end
	end

	// Bus multiplexer driven by the winning code
	always_comb begin
		case (encode_sel)
			cpu_pkg::SRC_Z_HI: bus_data = z_hi_data;
			cpu_pkg::SRC_Z_LO: bus_data = z_lo_data;
			cpu_pkg::SRC_PC:   bus_data = pc_data;
			cpu_pkg::SRC_MDR:  bus_data = mdr_data;
			cpu_pkg::SRC_NONE: bus_data = '0; // Idle bus
			default: begin
				// Codes 0..15, the encoder never produces 20..30
				bus_data = gpr_q[encode_sel[cpu_pkg::GPR_IDX_W-1:0]];
			end
		endcase
	end

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

	// Datapath sizing
	localparam int WORD_W    = 32;
	localparam int NUM_GPR   = 16;
	localparam int GPR_IDX_W = $clog2(NUM_GPR); // Index bits of one GPR
	localparam int OP_W      = 5;
	localparam int SRC_W     = 5;

	// ALU opcodes, zero is left unassigned
	localparam logic [OP_W-1:0] OP_AND  = 5'd1;
	localparam logic [OP_W-1:0] OP_OR   = 5'd2;
	localparam logic [OP_W-1:0] OP_ADD  = 5'd3;
	localparam logic [OP_W-1:0] OP_SUB  = 5'd4;
	localparam logic [OP_W-1:0] OP_MUL  = 5'd5;  // Signed 64-bit product
	localparam logic [OP_W-1:0] OP_DIV  = 5'd6;  // Remainder in high half
	localparam logic [OP_W-1:0] OP_SHR  = 5'd7;
	localparam logic [OP_W-1:0] OP_SHRA = 5'd8;
	localparam logic [OP_W-1:0] OP_SHL  = 5'd9;
	localparam logic [OP_W-1:0] OP_ROR  = 5'd10;
	localparam logic [OP_W-1:0] OP_ROL  = 5'd11;
	localparam logic [OP_W-1:0] OP_NEG  = 5'd12; // B only
	localparam logic [OP_W-1:0] OP_NOT  = 5'd13; // B only

	// Bus source codes
	// GPRs report their own index 0 to 15
	localparam logic [SRC_W-1:0] SRC_Z_HI = 5'd16;
	localparam logic [SRC_W-1:0] SRC_Z_LO = 5'd17;
	localparam logic [SRC_W-1:0] SRC_PC   = 5'd18;
	localparam logic [SRC_W-1:0] SRC_MDR  = 5'd19;
	localparam logic [SRC_W-1:0] SRC_NONE = 5'd31; // Nothing selected, bus idles at 0

endpackage

// ==== rtl/datapath.sv ====
`timescale 1ns/10ps

module datapath (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [cpu_pkg::NUM_GPR-1:0]  gpr_enable,
	input  logic [cpu_pkg::NUM_GPR-1:0]  gpr_select,
	input  logic                         pc_enable,
	input  logic                         pc_increment,
	input  logic                         ir_enable,
	input  logic                         y_enable,
	input  logic                         z_enable,
	input  logic                         mar_enable,
	input  logic                         mdr_enable,
	input  logic                         read,
	input  logic                         pc_select,
	input  logic                         z_hi_select,
	input  logic                         z_lo_select,
	input  logic                         mdr_select,
	input  logic [cpu_pkg::OP_W-1:0]     alu_op,
	input  logic [cpu_pkg::WORD_W-1:0]   mdata_in,
	output logic [cpu_pkg::WORD_W-1:0]   bus_data,
	output logic [cpu_pkg::SRC_W-1:0]    encode_sel,
	output logic [2*cpu_pkg::WORD_W-1:0] alu_result,
	output logic [cpu_pkg::WORD_W-1:0]   pc_data,
	output logic [cpu_pkg::WORD_W-1:0]   ir_data,
	output logic [cpu_pkg::WORD_W-1:0]   y_data,
	output logic [cpu_pkg::WORD_W-1:0]   z_hi_data,
	output logic [cpu_pkg::WORD_W-1:0]   z_lo_data,
	output logic [cpu_pkg::WORD_W-1:0]   mar_data,
	output logic [cpu_pkg::WORD_W-1:0]   mdr_data
);

	logic [cpu_pkg::WORD_W-1:0] gpr_q [cpu_pkg::NUM_GPR]; // R0..R15 contents

	gpr_file u_gpr_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.bus_data   (bus_data),
		.gpr_enable (gpr_enable),
		.gpr_q      (gpr_q)
	);

	// Sole driver of the shared bus
	bus_encoder u_bus_encoder (
		.gpr_q       (gpr_q),
		.gpr_select  (gpr_select),
		.pc_select   (pc_select),
		.z_hi_select (z_hi_select),
		.z_lo_select (z_lo_select),
		.mdr_select  (mdr_select),
		.pc_data     (pc_data),
		.z_hi_data   (z_hi_data),
		.z_lo_data   (z_lo_data),
		.mdr_data    (mdr_data),
		.bus_data    (bus_data),
		.encode_sel  (encode_sel)
	);

	alu u_alu (
		.a            (y_data),   // Operand A always from Y
		.b            (bus_data),
		.alu_op       (alu_op),
		.pc_increment (pc_increment),
		.result       (alu_result)
	);

	special_regs u_special_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.bus_data   (bus_data),
		.mdata_in   (mdata_in),
		.read       (read),
		.pc_enable  (pc_enable),
		.ir_enable  (ir_enable),
		.y_enable   (y_enable),
		.z_enable   (z_enable),
		.mar_enable (mar_enable),
		.mdr_enable (mdr_enable),
		.alu_result (alu_result),
		.pc_data    (pc_data),
		.ir_data    (ir_data),
		.y_data     (y_data),
		.z_hi_data  (z_hi_data),
		.z_lo_data  (z_lo_data),
		.mar_data   (mar_data),
		.mdr_data   (mdr_data)
	);

endmodule

// ==== rtl/gpr_file.sv ====
`timescale 1ns/10ps

module gpr_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cpu_pkg::WORD_W-1:0]    bus_data,
	input  logic [cpu_pkg::NUM_GPR-1:0]   gpr_enable,
	output logic [cpu_pkg::WORD_W-1:0]    gpr_q [cpu_pkg::NUM_GPR]
);

	// Sixteen bus-loaded registers R0..R15
	// Enables are independent, one bus word may land in several registers
	genvar i;
	generate
		for (i = 0; i < cpu_pkg::NUM_GPR; i++) begin : g_gpr
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					gpr_q[i] <= '0;
				end else if (gpr_enable[i]) begin
					gpr_q[i] <= bus_data; // Visible one cycle later
				end
			end
		end
	endgenerate

endmodule

// ==== rtl/special_regs.sv ====
`timescale 1ns/10ps

module special_regs (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [cpu_pkg::WORD_W-1:0]   bus_data,
	input  logic [cpu_pkg::WORD_W-1:0]   mdata_in,
	input  logic                         read,
	input  logic                         pc_enable,
	input  logic                         ir_enable,
	input  logic                         y_enable,
	input  logic                         z_enable,
	input  logic                         mar_enable,
	input  logic                         mdr_enable,
	input  logic [2*cpu_pkg::WORD_W-1:0] alu_result,
	output logic [cpu_pkg::WORD_W-1:0]   pc_data,
	output logic [cpu_pkg::WORD_W-1:0]   ir_data,
	output logic [cpu_pkg::WORD_W-1:0]   y_data,
	output logic [cpu_pkg::WORD_W-1:0]   z_hi_data,
	output logic [cpu_pkg::WORD_W-1:0]   z_lo_data,
	output logic [cpu_pkg::WORD_W-1:0]   mar_data,
	output logic [cpu_pkg::WORD_W-1:0]   mdr_data
);

	logic [2*cpu_pkg::WORD_W-1:0] z_q;
	logic [cpu_pkg::WORD_W-1:0]   mdr_in;

	// MDR source, memory when read is high
	assign mdr_in = read ? mdata_in : bus_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_data <= '0;
		end else if (pc_enable) begin
			pc_data <= bus_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir_data <= '0;
		end else if (ir_enable) begin
			ir_data <= bus_data;
		end
	end

	// Y holds operand A for the ALU
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			y_data <= '0;
		end else if (y_enable) begin
			y_data <= bus_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			z_q <= '0;
		end else if (z_enable) begin
			z_q <= alu_result; // All 64 bits at once
		end
	end

	assign z_hi_data = z_q[2*cpu_pkg::WORD_W-1:cpu_pkg::WORD_W];
	assign z_lo_data = z_q[cpu_pkg::WORD_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mar_data <= '0;
		end else if (mar_enable) begin
			mar_data <= bus_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mdr_data <= '0;
		end else if (mdr_enable) begin
			mdr_data <= mdr_in;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module datapath_tb -f vlog.f -o datapath_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/datapath_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== verif/datapath_input.txt ====
# Columns, all hex: opcode ra a_value rb b_value rd z_hi z_lo
# Opcodes: 01 AND 02 OR 03 ADD 04 SUB 05 MUL 06 DIV 07 SHR 08 SHRA 09 SHL 0a ROR 0b ROL 0c NEG 0d NOT
01 1 f0f01234 2 0ff0ff00 3 00000000 00f01200
02 4 a5000000 5 005a00ff 6 00000000 a55a00ff
03 7 ffffffff 8 00000002 9 00000000 00000001
04 a 00000005 b 00000007 c 00000000 fffffffe
05 1 fffffffd 2 00000007 d ffffffff ffffffeb
05 3 00010000 4 00010000 e 00000001 00000000
05 5 7fffffff 6 7fffffff f 3fffffff 00000001
06 1 00000011 2 00000005 0 00000002 00000003
06 3 ffffffef 4 00000005 5 fffffffe fffffffd
06 6 12345678 7 00000000 8 12345678 ffffffff
06 8 00000064 9 ffffffff a 00000000 ffffff9c
07 b 80000010 c 00000004 d 00000000 08000001
08 d 80000010 e 00000004 f 00000000 f8000001
09 f 00000001 0 0000001f 1 00000000 80000000
0a 1 12345678 2 00000000 3 00000000 12345678
0a 3 00000001 4 0000001f 5 00000000 00000002
0a 5 0000000f 6 00000004 7 00000000 f0000000
0b 7 deadbeef 8 00000000 9 00000000 deadbeef
0b 9 00000001 a 0000001f b 00000000 80000000
0b b 80000001 c 00000021 d 00000000 00000003
0c d aaaaaaaa e 00000005 d 00000000 fffffffb
0d 0 11111111 f 0f0f0f0f 1 00000000 f0f0f0f0
08 2 f0000000 3 00000021 4 00000000 f8000000

// ==== verif/datapath_props.sv ====
`timescale 1ns/10ps

module datapath_props (
	input logic                         clk,
	input logic                         rst_n,
	input logic [cpu_pkg::NUM_GPR-1:0]  gpr_enable,
	input logic [cpu_pkg::NUM_GPR-1:0]  gpr_select,
	input logic                         pc_enable,
	input logic                         ir_enable,
	input logic                         y_enable,
	input logic                         z_enable,
	input logic                         mar_enable,
	input logic                         mdr_enable,
	input logic                         read,
	input logic                         pc_select,
	input logic                         z_hi_select,
	input logic                         z_lo_select,
	input logic                         mdr_select,
	input logic [cpu_pkg::WORD_W-1:0]   bus_data,
	input logic [2*cpu_pkg::WORD_W-1:0] alu_result,
	input logic [cpu_pkg::WORD_W-1:0]   z_hi_data,
	input logic [cpu_pkg::WORD_W-1:0]   z_lo_data,
	input logic [cpu_pkg::WORD_W-1:0]   mar_data
);

	logic                        bus_load; // Some register takes the bus this cycle
	logic [cpu_pkg::NUM_GPR+3:0] selects;

	assign bus_load = (|gpr_enable) || pc_enable || ir_enable || y_enable || z_enable ||
		mar_enable || (mdr_enable && !read);
	assign selects = {gpr_select, pc_select, z_hi_select, z_lo_select, mdr_select};

	a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
		bus_load |-> $onehot0(selects))
		else $error("Several bus sources selected while a register loads from the bus");

	a_z_load: assert property (@(posedge clk) disable iff (!rst_n)
		z_enable |=> ({z_hi_data, z_lo_data} == $past(alu_result)))
		else $error("Z does not hold the ALU result of the previous cycle");

	a_mar_load: assert property (@(posedge clk) disable iff (!rst_n)
		mar_enable |=> (mar_data == $past(bus_data)))
		else $error("MAR does not hold the bus value of the previous cycle");

endmodule

bind datapath datapath_props u_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.gpr_enable  (gpr_enable),
	.gpr_select  (gpr_select),
	.pc_enable   (pc_enable),
	.ir_enable   (ir_enable),
	.y_enable    (y_enable),
	.z_enable    (z_enable),
	.mar_enable  (mar_enable),
	.mdr_enable  (mdr_enable),
	.read        (read),
	.pc_select   (pc_select),
	.z_hi_select (z_hi_select),
	.z_lo_select (z_lo_select),
	.mdr_select  (mdr_select),
	.bus_data    (bus_data),
	.alu_result  (alu_result),
	.z_hi_data   (z_hi_data),
	.z_lo_data   (z_lo_data),
	.mar_data    (mar_data)
);

// ==== verif/datapath_tb.sv ====
`timescale 1ns/10ps

module datapath_tb;

	localparam int PERIOD       = 8;
	localparam int RESET_CYCLES = 8;

	logic                         clk;
	logic                         rst_n;
	logic [cpu_pkg::NUM_GPR-1:0]  gpr_enable;
	logic [cpu_pkg::NUM_GPR-1:0]  gpr_select;
	logic                         pc_enable;
	logic                         pc_increment;
	logic                         ir_enable;
	logic                         y_enable;
	logic                         z_enable;
	logic                         mar_enable;
	logic                         mdr_enable;
	logic                         read;
	logic                         pc_select;
	logic                         z_hi_select;
	logic                         z_lo_select;
	logic                         mdr_select;
	logic [cpu_pkg::OP_W-1:0]     alu_op;
	logic [cpu_pkg::WORD_W-1:0]   mdata_in;
	logic [cpu_pkg::WORD_W-1:0]   bus_data;
	logic [cpu_pkg::SRC_W-1:0]    encode_sel;
	logic [2*cpu_pkg::WORD_W-1:0] alu_result;
	logic [cpu_pkg::WORD_W-1:0]   pc_data;
	logic [cpu_pkg::WORD_W-1:0]   ir_data;
	logic [cpu_pkg::WORD_W-1:0]   y_data;
	logic [cpu_pkg::WORD_W-1:0]   z_hi_data;
	logic [cpu_pkg::WORD_W-1:0]   z_lo_data;
	logic [cpu_pkg::WORD_W-1:0]   mar_data;
	logic [cpu_pkg::WORD_W-1:0]   mdr_data;

	int value_errors = 0;
	int other_errors = 0;
	int cycles       = 0;
	int cycle_limit  = 100; // Raised once the vectors are known

	// One entry per line of the stimulus file
	logic [cpu_pkg::OP_W-1:0]   vec_op [$];
	int                         vec_ra [$];
	int                         vec_rb [$];
	int                         vec_rd [$];
	logic [cpu_pkg::WORD_W-1:0] vec_a [$];
	logic [cpu_pkg::WORD_W-1:0] vec_b [$];
	logic [cpu_pkg::WORD_W-1:0] vec_hi [$];
	logic [cpu_pkg::WORD_W-1:0] vec_lo [$];

	datapath uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.gpr_enable   (gpr_enable),
		.gpr_select   (gpr_select),
		.pc_enable    (pc_enable),
		.pc_increment (pc_increment),
		.ir_enable    (ir_enable),
		.y_enable     (y_enable),
		.z_enable     (z_enable),
		.mar_enable   (mar_enable),
		.mdr_enable   (mdr_enable),
		.read         (read),
		.pc_select    (pc_select),
		.z_hi_select  (z_hi_select),
		.z_lo_select  (z_lo_select),
		.mdr_select   (mdr_select),
		.alu_op       (alu_op),
		.mdata_in     (mdata_in),
		.bus_data     (bus_data),
		.encode_sel   (encode_sel),
		.alu_result   (alu_result),
		.pc_data      (pc_data),
		.ir_data      (ir_data),
		.y_data       (y_data),
		.z_hi_data    (z_hi_data),
		.z_lo_data    (z_lo_data),
		.mar_data     (mar_data),
		.mdr_data     (mdr_data)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Run stopped by timeout after %0d cycles", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic idle_controls();
		gpr_enable   = '0;
		gpr_select   = '0;
		pc_enable    = 1'b0;
		pc_increment = 1'b0;
		ir_enable    = 1'b0;
		y_enable     = 1'b0;
		z_enable     = 1'b0;
		mar_enable   = 1'b0;
		mdr_enable   = 1'b0;
		read         = 1'b0;
		pc_select    = 1'b0;
		z_hi_select  = 1'b0;
		z_lo_select  = 1'b0;
		mdr_select   = 1'b0;
		alu_op       = '0;
		mdata_in     = '0;
	endtask

	// Controls change just after the edge and idle unless set again
	task automatic next_cycle();
		@(posedge clk);
		#1;
		idle_controls();
	endtask

	task automatic check_word(input string name, input logic [cpu_pkg::WORD_W-1:0] got,
			input logic [cpu_pkg::WORD_W-1:0] expected);
		if (got !== expected) begin
			value_errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_src(input string name, input logic [cpu_pkg::SRC_W-1:0] got,
			input logic [cpu_pkg::SRC_W-1:0] expected);
		if (got !== expected) begin
			value_errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic load_vectors();
		int                         fd;
		int                         code;
		string                      line;
		logic [cpu_pkg::OP_W-1:0]   op;
		int                         ra;
		int                         rb;
		int                         rd;
		logic [cpu_pkg::WORD_W-1:0] a;
		logic [cpu_pkg::WORD_W-1:0] b;
		logic [cpu_pkg::WORD_W-1:0] hi;
		logic [cpu_pkg::WORD_W-1:0] lo;
		fd = $fopen("verif/datapath_input.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the stimulus file verif/datapath_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line[0] == "#") begin
				continue; // Blank or comment line
			end
			code = $sscanf(line, "%h %h %h %h %h %h %h %h", op, ra, a, rb, b, rd, hi, lo);
			if (code != 8) begin
				other_errors++;
				$display("Stimulus line could not be parsed: %s", line);
			end else begin
				vec_op.push_back(op);
				vec_ra.push_back(ra);
				vec_a.push_back(a);
				vec_rb.push_back(rb);
				vec_b.push_back(b);
				vec_rd.push_back(rd);
				vec_hi.push_back(hi);
				vec_lo.push_back(lo);
			end
		end
		$fclose(fd);
		if (vec_op.size() == 0) begin
			other_errors++;
			$display("The stimulus file held no vectors");
		end
	endtask

	task automatic check_reset();
		@(negedge clk);
		check_word("pc_data", pc_data, '0);
		check_word("ir_data", ir_data, '0);
		check_word("y_data", y_data, '0);
		check_word("z_hi_data", z_hi_data, '0);
		check_word("z_lo_data", z_lo_data, '0);
		check_word("mar_data", mar_data, '0);
		check_word("mdr_data", mdr_data, '0);
		for (int i = 0; i < cpu_pkg::NUM_GPR; i++) begin
			next_cycle();
			gpr_select[i] = 1'b1;
			@(negedge clk);
			check_word($sformatf("bus_data (R%0d)", i), bus_data, '0);
			check_src("encode_sel", encode_sel, i[cpu_pkg::SRC_W-1:0]);
		end
	endtask

	// Load Ra and Rb through MDR, then Y, Z and write-back
	task automatic run_vector(input int i);
		int ra;
		int rb;
		int rd;
		ra = vec_ra[i];
		rb = vec_rb[i];
		rd = vec_rd[i];
		next_cycle();
		read       = 1'b1;
		mdr_enable = 1'b1;
		mdata_in   = vec_a[i];
		next_cycle();
		mdr_select     = 1'b1;
		gpr_enable[ra] = 1'b1;
		next_cycle();
		read       = 1'b1;
		mdr_enable = 1'b1;
		mdata_in   = vec_b[i];
		next_cycle();
		mdr_select     = 1'b1;
		gpr_enable[rb] = 1'b1;
		next_cycle();
		gpr_select[ra] = 1'b1;
		y_enable       = 1'b1;
		next_cycle();
		gpr_select[rb] = 1'b1;
		alu_op         = vec_op[i];
		z_enable       = 1'b1;
		@(negedge clk);
		check_word($sformatf("vector %0d y_data", i), y_data, vec_a[i]);
		check_word($sformatf("vector %0d alu_result[63:32]", i),
			alu_result[2*cpu_pkg::WORD_W-1:cpu_pkg::WORD_W], vec_hi[i]);
		check_word($sformatf("vector %0d alu_result[31:0]", i),
			alu_result[cpu_pkg::WORD_W-1:0], vec_lo[i]);
		next_cycle();
		z_lo_select    = 1'b1;
		gpr_enable[rd] = 1'b1;
		@(negedge clk);
		check_word($sformatf("vector %0d z_hi_data", i), z_hi_data, vec_hi[i]);
		check_word($sformatf("vector %0d z_lo_data", i), z_lo_data, vec_lo[i]);
		next_cycle();
		gpr_select[rd] = 1'b1;
		@(negedge clk);
		check_word($sformatf("vector %0d bus_data (Rd)", i), bus_data, vec_lo[i]);
		check_src("encode_sel", encode_sel, rd[cpu_pkg::SRC_W-1:0]);
		if (rd != ra) begin
			next_cycle();
			gpr_select[ra] = 1'b1;
			@(negedge clk);
			check_word($sformatf("vector %0d bus_data (Ra)", i), bus_data, vec_a[i]);
		end
	endtask

	task automatic run_fetch();
		logic [cpu_pkg::WORD_W-1:0] pc_start;
		logic [cpu_pkg::WORD_W-1:0] fetched;
		pc_start = 32'h0000_0100;
		fetched  = 32'h8c21_0004;
		next_cycle();
		read       = 1'b1;
		mdr_enable = 1'b1;
		mdata_in   = pc_start;
		next_cycle();
		mdr_select = 1'b1;
		pc_enable  = 1'b1;
		next_cycle(); // T0
		pc_select    = 1'b1;
		mar_enable   = 1'b1;
		pc_increment = 1'b1;
		z_enable     = 1'b1;
		next_cycle(); // T1
		z_lo_select = 1'b1;
		pc_enable   = 1'b1;
		read        = 1'b1;
		mdr_enable  = 1'b1;
		mdata_in    = fetched;
		next_cycle(); // T2
		mdr_select = 1'b1;
		ir_enable  = 1'b1;
		next_cycle();
		@(negedge clk);
		check_word("mar_data", mar_data, pc_start);
		check_word("pc_data", pc_data, pc_start + 32'd1);
		check_word("ir_data", ir_data, fetched);
	endtask

	task automatic check_priority();
		logic [cpu_pkg::WORD_W-1:0] r3_value;
		logic [cpu_pkg::WORD_W-1:0] mdr_value;
		r3_value  = 32'h0000_3333;
		mdr_value = 32'h0000_9999; // Differs from R3 so the winner shows
		next_cycle();
		read       = 1'b1;
		mdr_enable = 1'b1;
		mdata_in   = r3_value;
		next_cycle();
		mdr_select    = 1'b1;
		gpr_enable[3] = 1'b1;
		next_cycle();
		read       = 1'b1;
		mdr_enable = 1'b1;
		mdata_in   = mdr_value;
		next_cycle();
		gpr_select[3] = 1'b1;
		mdr_select    = 1'b1;
		@(negedge clk);
		check_src("encode_sel", encode_sel, 5'd3);
		check_word("bus_data", bus_data, r3_value);
		next_cycle();
		@(negedge clk);
		check_src("encode_sel", encode_sel, cpu_pkg::SRC_NONE);
		check_word("bus_data", bus_data, '0);
	endtask

	initial begin
		rst_n = 1'b0;
		idle_controls();
		load_vectors();
		cycle_limit = 20 * vec_op.size() + 100;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_reset();
		foreach (vec_op[i]) begin
			run_vector(i);
		end
		run_fetch();
		check_priority();
		$display("Vectors: %0d, value errors: %0d, other errors: %0d",
			vec_op.size(), value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/cpu_pkg.sv
rtl/gpr_file.sv
rtl/bus_encoder.sv
rtl/alu.sv
rtl/special_regs.sv
rtl/datapath.sv
verif/datapath_props.sv
verif/datapath_tb.sv
